// File: include/motor_settings.svh
`ifndef MOTOR_SETTINGS_SVH
`define MOTOR_SETTINGS_SVH

// step period in clock cycles
`define STEP_PERIOD_W 10

// duty and pwm counter share this width, so one pwm period is 2**DUTY_W cycles
`define DUTY_W 8

// commutation floor in clock cycles
`define MIN_STEP_PERIOD 64

`endif

// File: src/motorPkg.sv
`include "motor_settings.svh"

package motorPkg;

    typedef logic [`STEP_PERIOD_W-1:0] stepPeriodT;
    typedef logic [`DUTY_W-1:0] dutyT;

    // bit 0 is phase a, bit 1 phase b, bit 2 phase c
    typedef logic [2:0] legSelT;

    localparam legSelT LEG_NONE = 3'b000;
    localparam legSelT LEG_A = 3'b001;
    localparam legSelT LEG_B = 3'b010;
    localparam legSelT LEG_C = 3'b100;

    // bridge states are named high side first, then low side
    typedef enum logic [2:0] {
        IDLE,
        AB,
        AC,
        BC,
        BA,
        CA,
        CB
    } commStateT;

endpackage

// File: src/commandLatch.sv
`include "motor_settings.svh"

module commandLatch (
    input  logic               clk,
    input  logic               nRst,
    input  logic               run,
    input  logic               reverse,
    input  motorPkg::stepPeriodT stepPeriod,
    input  motorPkg::dutyT     duty,
    output logic               runQ,
    output logic               reverseQ,
    output motorPkg::stepPeriodT periodQ,
    output motorPkg::dutyT     dutyQ
);

    localparam motorPkg::stepPeriodT MinPeriod = motorPkg::stepPeriodT'(`MIN_STEP_PERIOD);

    motorPkg::stepPeriodT clampedPeriod;

    // never let the bridge commutate faster than the floor
    always_comb begin
        if (stepPeriod < MinPeriod) begin
            clampedPeriod = MinPeriod;
        end else begin
            clampedPeriod = stepPeriod;
        end
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            runQ <= 1'b0;
            reverseQ <= 1'b0;
            periodQ <= MinPeriod;
            dutyQ <= '0;
        end else begin
            runQ <= run;
            reverseQ <= reverse;
            periodQ <= clampedPeriod;
            dutyQ <= duty;
        end
    end

endmodule

// File: src/stepTimer.sv
module stepTimer (
    input  logic                 clk,
    input  logic                 nRst,
    input  logic                 runQ,
    input  motorPkg::stepPeriodT periodQ,
    output logic                 stepTick
);

    motorPkg::stepPeriodT count;
    motorPkg::stepPeriodT lastCount;
    logic atEnd;

    // periodQ is clamped upstream, so it is never zero while running
    assign lastCount = periodQ - motorPkg::stepPeriodT'(1);

    // a shortened period can leave the count past the new end,
    // which then wraps on the next cycle instead of running around
    assign atEnd = (count >= lastCount);

    assign stepTick = runQ && atEnd;

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            count <= '0;
        end else if (!runQ) begin
            count <= '0;
        end else if (atEnd) begin
            count <= '0;
        end else begin
            count <= count + motorPkg::stepPeriodT'(1);
        end
    end

endmodule

// File: src/commutator.sv
module commutator (
    input  logic             clk,
    input  logic             nRst,
    input  logic             runQ,
    input  logic             reverseQ,
    input  logic             stepTick,
    output motorPkg::legSelT highSel,
    output motorPkg::legSelT lowSel
);

    motorPkg::commStateT state;
    motorPkg::commStateT stateNext;

    // one position along AB, AC, BC, BA, CA, CB in either direction
    function automatic motorPkg::commStateT stepState(
        input motorPkg::commStateT cur,
        input logic rev
    );
        motorPkg::commStateT nxt;
        case (cur)
            motorPkg::AB: nxt = rev ? motorPkg::CB : motorPkg::AC;
            motorPkg::AC: nxt = rev ? motorPkg::AB : motorPkg::BC;
            motorPkg::BC: nxt = rev ? motorPkg::AC : motorPkg::BA;
            motorPkg::BA: nxt = rev ? motorPkg::BC : motorPkg::CA;
            motorPkg::CA: nxt = rev ? motorPkg::BA : motorPkg::CB;
            motorPkg::CB: nxt = rev ? motorPkg::CA : motorPkg::AB;
            default: nxt = motorPkg::AB;
        endcase
        return nxt;
    endfunction

    always_comb begin
        if (!runQ) begin
            stateNext = motorPkg::IDLE;
        end else if (state == motorPkg::IDLE) begin
            stateNext = motorPkg::AB;
        end else if (stepTick) begin
            stateNext = stepState(state, reverseQ);
        end else begin
            stateNext = state;
        end
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            state <= motorPkg::IDLE;
        end else begin
            state <= stateNext;
        end
    end

    // high side leg first, low side leg second
    always_comb begin
        case (state)
            motorPkg::AB: begin
                highSel = motorPkg::LEG_A;
                lowSel = motorPkg::LEG_B;
            end
            motorPkg::AC: begin
                highSel = motorPkg::LEG_A;
                lowSel = motorPkg::LEG_C;
            end
            motorPkg::BC: begin
                highSel = motorPkg::LEG_B;
                lowSel = motorPkg::LEG_C;
            end
            motorPkg::BA: begin
                highSel = motorPkg::LEG_B;
                lowSel = motorPkg::LEG_A;
            end
            motorPkg::CA: begin
                highSel = motorPkg::LEG_C;
                lowSel = motorPkg::LEG_A;
            end
            motorPkg::CB: begin
                highSel = motorPkg::LEG_C;
                lowSel = motorPkg::LEG_B;
            end
            default: begin
                highSel = motorPkg::LEG_NONE;
                lowSel = motorPkg::LEG_NONE;
            end
        endcase
    end

endmodule

// File: src/pwmGen.sv
module pwmGen (
    input  logic           clk,
    input  logic           nRst,
    input  motorPkg::dutyT dutyQ,
    output logic           pwmOn
);

    motorPkg::dutyT pwmCount;

    // free running, wraps every 256 cycles
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            pwmCount <= '0;
        end else begin
            pwmCount <= pwmCount + motorPkg::dutyT'(1);
        end
    end

    // edge aligned, on at the start of each period
    // duty 0 never turns on, full scale leaves one off cycle
    assign pwmOn = (pwmCount < dutyQ);

endmodule

// File: src/gateDriver.sv
module gateDriver (
    input  logic             clk,
    input  logic             nRst,
    input  logic             pwmOn,
    input  motorPkg::legSelT highSel,
    input  motorPkg::legSelT lowSel,
    output logic             aHp,
    output logic             bHp,
    output logic             cHp,
    output logic             aLn,
    output logic             bLn,
    output logic             cLn
);

    motorPkg::legSelT highOn;
    motorPkg::legSelT lowOn;

    // both sides of the active pair are chopped together
    assign highOn = highSel & {3{pwmOn}};
    assign lowOn = lowSel & {3{pwmOn}};

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            aHp <= 1'b0;
            bHp <= 1'b0;
            cHp <= 1'b0;
            // low side drivers are active low, so 1 is off
            aLn <= 1'b1;
            bLn <= 1'b1;
            cLn <= 1'b1;
        end else begin
            aHp <= highOn[0];
            bHp <= highOn[1];
            cHp <= highOn[2];
            aLn <= ~lowOn[0];
            bLn <= ~lowOn[1];
            cLn <= ~lowOn[2];
        end
    end

endmodule

// File: src/motorDriveTop.sv
module motorDriveTop (
    input  logic                 clk,
    input  logic                 nRst,
    input  logic                 run,
    input  logic                 reverse,
    input  motorPkg::stepPeriodT stepPeriod,
    input  motorPkg::dutyT       duty,
    output logic                 aHp,
    output logic                 bHp,
    output logic                 cHp,
    output logic                 aLn,
    output logic                 bLn,
    output logic                 cLn
);

    logic runQ;
    logic reverseQ;
    motorPkg::stepPeriodT periodQ;
    motorPkg::dutyT dutyQ;
    logic stepTick;
    logic pwmOn;
    motorPkg::legSelT highSel;
    motorPkg::legSelT lowSel;

    commandLatch uCommandLatch (
        .clk(clk),
        .nRst(nRst),
        .run(run),
        .reverse(reverse),
        .stepPeriod(stepPeriod),
        .duty(duty),
        .runQ(runQ),
        .reverseQ(reverseQ),
        .periodQ(periodQ),
        .dutyQ(dutyQ)
    );

    stepTimer uStepTimer (
        .clk(clk),
        .nRst(nRst),
        .runQ(runQ),
        .periodQ(periodQ),
        .stepTick(stepTick)
    );

    commutator uCommutator (
        .clk(clk),
        .nRst(nRst),
        .runQ(runQ),
        .reverseQ(reverseQ),
        .stepTick(stepTick),
        .highSel(highSel),
        .lowSel(lowSel)
    );

    pwmGen uPwmGen (
        .clk(clk),
        .nRst(nRst),
        .dutyQ(dutyQ),
        .pwmOn(pwmOn)
    );

    gateDriver uGateDriver (
        .clk(clk),
        .nRst(nRst),
        .pwmOn(pwmOn),
        .highSel(highSel),
        .lowSel(lowSel),
        .aHp(aHp),
        .bHp(bHp),
        .cHp(cHp),
        .aLn(aLn),
        .bLn(bLn),
        .cLn(cLn)
    );

endmodule

// File: test/clockGen.sv
module clockGen (
    output logic clk,
    output logic nRst
);

    localparam int HalfPeriod = 5;
    localparam int ResetCycles = 4;

    initial begin
        clk = 1'b0;
        forever begin
            #HalfPeriod clk = ~clk;
        end
    end

    // release on a falling edge, clear of the rising edges
    initial begin
        nRst = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        nRst = 1'b1;
    end

endmodule

// File: test/motorDriveTb.sv
`include "motor_settings.svh"

module motorDriveTb;

    localparam string VectorFile = "test/motor_vectors.txt";
    localparam int PwmPeriod = 1 << `DUTY_W;
    // latch, state register and gate register each add a cycle
    localparam int StopLatency = 4;
    localparam int GapCycles = 8;
    localparam int MarginCycles = 200;

    logic clk;
    logic nRst;
    logic run;
    logic reverse;
    motorPkg::stepPeriodT stepPeriod;
    motorPkg::dutyT duty;
    logic aHp;
    logic bHp;
    logic cHp;
    logic aLn;
    logic bLn;
    logic cLn;

    string tName[$];
    int tRun[$];
    int tReverse[$];
    int tPeriod[$];
    int tDuty[$];
    int tCycles[$];
    int tDir[$];
    int tMinSteps[$];

    logic [15:0] lfsrState = 16'd56982;
    int errors = 0;
    int checks = 0;
    int cycleCount = 0;
    int cycleLimit = 0;
    string curName = "reset";
    int testIdx = -1;

    // running totals kept by the monitor
    int monErrors = 0;
    int monChecks = 0;
    int seenTest = -1;
    int lastState = -1;
    int fwdSteps = 0;
    int backSteps = 0;
    int highOnCycles = 0;
    int lowOnCycles = 0;
    int runLowFor = 0;

    clockGen uClockGen (
        .clk(clk),
        .nRst(nRst)
    );

    motorDriveTop dut (
        .clk(clk),
        .nRst(nRst),
        .run(run),
        .reverse(reverse),
        .stepPeriod(stepPeriod),
        .duty(duty),
        .aHp(aHp),
        .bHp(bHp),
        .cHp(cHp),
        .aLn(aLn),
        .bLn(bLn),
        .cLn(cLn)
    );

    // x^16 + x^14 + x^13 + x^11 + 1, new bit enters at the lsb
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic drawDuty(output motorPkg::dutyT d);
        int i;
        d = '0;
        for (i = 0; i < `DUTY_W; i++) begin
            lfsrState = lfsrNext(lfsrState);
            d = {d[`DUTY_W-2:0], lfsrState[0]};
        end
        // zero would leave nothing to measure
        if (d == '0) begin
            d = motorPkg::dutyT'(1);
        end
    endtask

    function automatic int firstOn(input logic [2:0] legs);
        if (legs[0]) begin
            return 0;
        end else if (legs[1]) begin
            return 1;
        end else if (legs[2]) begin
            return 2;
        end
        return -1;
    endfunction

    // positions 0 to 5 along AB, AC, BC, BA, CA, CB, legs a=0 b=1 c=2
    function automatic int stateOf(input int hi, input int lo);
        int pos;
        case (hi * 3 + lo)
            1: pos = 0;
            2: pos = 1;
            5: pos = 2;
            3: pos = 3;
            6: pos = 4;
            7: pos = 5;
            default: pos = -1;
        endcase
        return pos;
    endfunction

    task automatic checkValue(input string what, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("Fail %s: %s expected %0d actual %0d", curName, what, expected, actual);
        end
    endtask

    task automatic checkRange(input string what, input int low, input int high, input int actual);
        checks++;
        assert (actual >= low && actual <= high) else begin
            errors++;
            $display("Fail %s: %s expected %0d to %0d actual %0d",
                curName, what, low, high, actual);
        end
    endtask

    task automatic loadVectors();
        int fd;
        int n;
        string line;
        string name;
        int r;
        int rv;
        int p;
        int du;
        int cy;
        int dir;
        int ms;
        fd = $fopen(VectorFile, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%s %d %d %d %d %d %d %d", name, r, rv, p, du, cy, dir, ms);
                    if (n == 8) begin
                        tName.push_back(name);
                        tRun.push_back(r);
                        tReverse.push_back(rv);
                        tPeriod.push_back(p);
                        tDuty.push_back(du);
                        tCycles.push_back(cy);
                        tDir.push_back(dir);
                        tMinSteps.push_back(ms);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic scoreTest(input int idx, input int d, input int fwd, input int back,
                             input int highOn, input int lowOn);
        int floorPeriod;
        int windows;
        if (tRun[idx] == 0) begin
            checkValue("steps while stopped", 0, fwd + back);
            checkValue("gate on-cycles while stopped", 0, highOn + lowOn);
        end else begin
            floorPeriod = tPeriod[idx];
            if (floorPeriod < `MIN_STEP_PERIOD) begin
                floorPeriod = `MIN_STEP_PERIOD;
            end
            checkRange("steps", tMinSteps[idx], tCycles[idx] / floorPeriod + 1, fwd + back);
            if (tDir[idx] > 0) begin
                checkValue("backward steps", 0, back);
            end else if (tDir[idx] < 0) begin
                checkValue("forward steps", 0, fwd);
            end
            windows = tCycles[idx] / PwmPeriod;
            checkRange("high-side on-cycles", d * windows - d, d * windows + d, highOn);
            // the low side is chopped along with the high side
            checkRange("low-side on-cycles", d * windows - d, d * windows + d, lowOn);
        end
    endtask

    task automatic runTests();
        motorPkg::dutyT d;
        int i;
        int fwd0;
        int back0;
        int high0;
        int low0;
        for (i = 0; i < tName.size(); i++) begin
            if (tDuty[i] < 0) begin
                drawDuty(d);
            end else begin
                d = motorPkg::dutyT'(tDuty[i]);
            end
            curName = tName[i];
            testIdx = i;
            fwd0 = fwdSteps;
            back0 = backSteps;
            high0 = highOnCycles;
            low0 = lowOnCycles;
            run <= (tRun[i] != 0);
            reverse <= (tReverse[i] != 0);
            stepPeriod <= motorPkg::stepPeriodT'(tPeriod[i]);
            duty <= d;
            repeat (tCycles[i]) @(posedge clk);
            run <= 1'b0;
            repeat (GapCycles) @(posedge clk);
            scoreTest(i, int'(d), fwdSteps - fwd0, backSteps - back0,
                highOnCycles - high0, lowOnCycles - low0);
        end
    endtask

    // outputs settle after the rising edge, so look at them on the falling edge
    always @(negedge clk) begin
        logic [2:0] highOn;
        logic [2:0] lowOn;
        int highCount;
        int lowCount;
        int st;
        int diff;
        highOn = {cHp, bHp, aHp};
        lowOn = ~{cLn, bLn, aLn};
        highCount = int'(highOn[0]) + int'(highOn[1]) + int'(highOn[2]);
        lowCount = int'(lowOn[0]) + int'(lowOn[1]) + int'(lowOn[2]);
        if (run) begin
            runLowFor = 0;
        end else begin
            runLowFor++;
        end
        if (testIdx != seenTest) begin
            seenTest = testIdx;
            lastState = -1;
        end
        monChecks++;
        assert (highCount <= 1 && lowCount <= 1 && (highOn & lowOn) == 3'b000) else begin
            monErrors++;
            $display("unsafe gate pattern in test %s: high legs %b, low legs %b",
                curName, highOn, lowOn);
        end
        if (!nRst || runLowFor >= StopLatency) begin
            monChecks++;
            assert (highOn == 3'b000 && lowOn == 3'b000) else begin
                monErrors++;
                $display("gates still on while stopped in test %s", curName);
            end
        end
        highOnCycles += highCount;
        lowOnCycles += lowCount;
        if (highCount == 1 && lowCount == 1) begin
            st = stateOf(firstOn(highOn), firstOn(lowOn));
            if (st >= 0 && lastState < 0) begin
                monChecks++;
                assert (st == 0) else begin
                    monErrors++;
                    $display("Fail %s: first state expected 0 actual %0d", curName, st);
                end
            end else if (st >= 0) begin
                diff = (st - lastState + 6) % 6;
                if (diff == 1) begin
                    fwdSteps++;
                end else if (diff == 5) begin
                    backSteps++;
                end
                monChecks++;
                assert (diff <= 1 || diff == 5) else begin
                    monErrors++;
                    $display("bridge state jumped %0d positions in test %s", diff, curName);
                end
            end
            lastState = st;
        end
    end

    initial begin : watchdog
        wait (cycleLimit > 0);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount = cycleCount + 1;
        end
        $display("timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("tests failed");
        $finish;
    end

    initial begin
        int total;
        int i;
        run = 1'b0;
        reverse = 1'b0;
        stepPeriod = '0;
        duty = '0;
        loadVectors();
        total = MarginCycles;
        for (i = 0; i < tName.size(); i++) begin
            total += tCycles[i] + GapCycles;
        end
        cycleLimit = total;
        if (tName.size() == 0) begin
            $display("no test could be read from %s", VectorFile);
            $display("tests failed");
            $finish;
        end else begin
            wait (nRst === 1'b1);
            @(posedge clk);
            runTests();
            $display("%0d checks, %0d errors", checks + monChecks, errors + monErrors);
            if (errors + monErrors == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

endmodule

// File: list.f
+incdir+include
src/motorPkg.sv
src/commandLatch.sv
src/stepTimer.sv
src/commutator.sv
src/pwmGen.sv
src/gateDriver.sv
src/motorDriveTop.sv
test/clockGen.sv
test/motorDriveTb.sv

// File: run.sh
#!/bin/sh
# build the motor drive testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module motorDriveTb -f list.f -o simMotor
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/simMotor)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1

// File: test/motor_vectors.txt
# name run reverse stepPeriod duty cycles expectedDirection minSteps
# duty -1 draws from the lfsr, direction 1 forward, -1 backward, 0 not checked
idleStart 0 0 200 128 512 0 0
fwdSlow 1 0 300 128 2560 1 6
revSlow 1 1 300 128 2560 -1 6
fwdFast 1 0 64 220 1024 1 14
clampLow 1 0 10 220 1024 1 14
clampZero 1 1 0 230 1024 -1 14
clampEdge 1 0 63 200 1024 1 14
dutyZero 1 0 100 0 768 0 0
dutyFull 1 1 100 255 1024 -1 8
dutyHalf 1 0 400 128 1536 1 1
randDutyA 1 0 300 -1 1536 1 3
randDutyB 1 1 300 -1 1536 -1 3
randDutyC 1 0 512 -1 2048 1 2
stopMid 0 1 300 128 256 0 0
revFast 1 1 64 200 768 -1 10
